/* hw/hb_dec_pkg.sv */
/*
   Half-band I/Q decimator shared definitions.
   Sample and accumulator widths, the fixed filter taps, the I/Q sample
   struct and the operating mode encoding.
*/
package hb_dec_pkg;

   // one rail sample and the full-precision product/accumulator.
   localparam int sample_w = 18;
   localparam int acc_w = 36;

   // width of the delivered output sample counter.
   localparam int count_w = 16;

   // taps of the seven-tap response A 0 B 1/2 B 0 A, scaled by 2^18.
   // The centre tap of one half is applied as a shift, not a multiply.
   localparam logic signed [sample_w-1:0] coeff_a = -18'sd10690;
   localparam logic signed [sample_w-1:0] coeff_b = 18'sd75809;

   // one complex sample, I in the upper half of the packed word.
   typedef struct packed
   {
      logic signed [sample_w-1:0] i;
      logic signed [sample_w-1:0] q;
   } iq_sample_t;

   // operating modes of the decimator.
   typedef enum logic
   {
      MODE_DECIMATE = 1'b0,
      MODE_BYPASS   = 1'b1
   } dec_mode_e;

endpackage

/* hw/hb_round.sv */
`timescale 1ns/1ps
/*
   Accumulator rounding.
   Reduces the 36-bit accumulator to an 18-bit sample, round to nearest
   with ties going upward.
*/
module hb_round
(
   input  logic [hb_dec_pkg::acc_w-1:0]    in,
   output logic [hb_dec_pkg::sample_w-1:0] out
);

   logic [hb_dec_pkg::acc_w-1:0] half_lsb;
   logic [hb_dec_pkg::acc_w-1:0] biased;

   // half of one output LSB sits just below the kept bits.
   assign half_lsb = {{(hb_dec_pkg::acc_w-1){1'b0}}, 1'b1}
                     << (hb_dec_pkg::acc_w - hb_dec_pkg::sample_w - 1);

   assign biased = in + half_lsb;
   assign out = biased[hb_dec_pkg::acc_w-1 -: hb_dec_pkg::sample_w];

endmodule

/* hw/hb_mult18.sv */
`timescale 1ns/1ps
/*
   Signed 18x18 multiplier.
   Behavioural model of a hard multiplier block with clock enable,
   synchronous reset and a registered 36-bit product.
*/
module hb_mult18
(
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  ce,
   input  logic signed [hb_dec_pkg::sample_w-1:0] a,
   input  logic signed [hb_dec_pkg::sample_w-1:0] b,
   output logic signed [hb_dec_pkg::acc_w-1:0]    p
);

   // the product only changes when enabled, as in the hard block.
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         p <= '0;
      end
      else if (ce)
      begin
         p <= a * b;
      end
   end

endmodule

/* hw/small_hb_dec.sv */
`timescale 1ns/1ps
/*
   Short half-band decimate-by-two filter for one real rail.
   Response A 0 B 1/2 B 0 A on a single shared multiplier, or a straight
   pass of every input sample when bypass is set.
*/
module small_hb_dec
(
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  flush,
   input  logic                                  bypass,
   input  logic                                  stb_in,
   input  logic signed [hb_dec_pkg::sample_w-1:0] data_in,
   output logic                                  stb_out,
   output logic signed [hb_dec_pkg::sample_w-1:0] data_out
);

   logic                                  clr;
   logic                                  stb_in_d1;
   logic signed [hb_dec_pkg::sample_w-1:0] data_in_d1;
   logic                                  phase;
   logic                                  go;
   logic                                  go_d1;
   logic                                  go_d2;
   logic                                  go_d3;
   logic                                  go_d4;
   logic signed [hb_dec_pkg::sample_w-1:0] d1, d2, d3, d4, d5, d6;
   logic        [hb_dec_pkg::sample_w:0]   sum_a_full;
   logic        [hb_dec_pkg::sample_w:0]   sum_b_full;
   logic signed [hb_dec_pkg::sample_w-1:0] sum_a;
   logic signed [hb_dec_pkg::sample_w-1:0] sum_b;
   logic signed [hb_dec_pkg::sample_w-1:0] middle;
   logic signed [hb_dec_pkg::sample_w-1:0] mult_a;
   logic signed [hb_dec_pkg::sample_w-1:0] mult_b;
   logic signed [hb_dec_pkg::acc_w-1:0]    prod;
   logic        [hb_dec_pkg::acc_w-1:0]    accum;
   logic        [hb_dec_pkg::sample_w-1:0] accum_rnd;
   logic signed [hb_dec_pkg::sample_w-1:0] final_sum;

   // a mode change restarts the filter exactly like a reset.
   assign clr = rst | flush;

   always_ff @(posedge clk)
   begin
      data_in_d1 <= data_in;
      if (rst)
         stb_in_d1 <= 1'b0;
      else
         stb_in_d1 <= stb_in;
   end

   // the second strobe of each pair starts a computation.
   assign go = stb_in_d1 & phase;

   always_ff @(posedge clk)
   begin
      if (clr)
      begin
         phase <= 1'b0;
         go_d1 <= 1'b0;
         go_d2 <= 1'b0;
         go_d3 <= 1'b0;
         go_d4 <= 1'b0;
      end
      else
      begin
         if (stb_in_d1)
            phase <= ~phase;
         go_d1 <= go;
         go_d2 <= go_d1;
         go_d3 <= go_d2;
         go_d4 <= go_d3;
      end
   end

   // six-deep history, d1 is one sample back.
   always_ff @(posedge clk)
   begin
      if (clr)
      begin
         d1 <= '0;
         d2 <= '0;
         d3 <= '0;
         d4 <= '0;
         d5 <= '0;
         d6 <= '0;
      end
      else if (stb_in_d1)
      begin
         d1 <= data_in_d1;
         d2 <= d1;
         d3 <= d2;
         d4 <= d3;
         d5 <= d4;
         d6 <= d5;
      end
   end

   // symmetric taps share one multiply, the halving keeps 18 bits.
   assign sum_a_full = {data_in_d1[hb_dec_pkg::sample_w-1], data_in_d1}
                       + {d6[hb_dec_pkg::sample_w-1], d6};
   assign sum_b_full = {d2[hb_dec_pkg::sample_w-1], d2}
                       + {d4[hb_dec_pkg::sample_w-1], d4};

   always_ff @(posedge clk)
   begin
      if (go)
      begin
         sum_a <= sum_a_full[hb_dec_pkg::sample_w:1];
         sum_b <= sum_b_full[hb_dec_pkg::sample_w:1];
         middle <= d3;
      end
   end

   // outer pair on the first multiplier cycle, inner pair on the second.
   assign mult_a = go_d2 ? hb_dec_pkg::coeff_b : hb_dec_pkg::coeff_a;
   assign mult_b = go_d2 ? sum_b : sum_a;

   hb_mult18 mult
   (
      .clk (clk),
      .rst (clr),
      .ce  (go_d1 | go_d2),
      .a   (mult_a),
      .b   (mult_b),
      .p   (prod)
   );

   // the centre tap of 1/2 is the sample placed at weight 2^16.
   always_ff @(posedge clk)
   begin
      if (clr)
         accum <= '0;
      else if (go_d2)
         accum <= {{2{middle[hb_dec_pkg::sample_w-1]}}, middle,
                   {(hb_dec_pkg::acc_w-hb_dec_pkg::sample_w-2){1'b0}}} + prod;
      else if (go_d3)
         accum <= accum + prod;
   end

   hb_round round_acc
   (
      .in  (accum),
      .out (accum_rnd)
   );

   always_ff @(posedge clk)
   begin
      if (bypass)
         final_sum <= data_in_d1;
      else if (go_d4)
         final_sum <= accum_rnd;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         stb_out <= 1'b0;
      else if (bypass)
         stb_out <= stb_in_d1;
      else
         stb_out <= go_d4;
   end

   assign data_out = final_sum;

endmodule

/* hw/iq_input_stage.sv */
`timescale 1ns/1ps
/*
   I/Q input stage.
   Registers the incoming complex sample and its strobe, splits it into
   the two rails and flushes the filters whenever the mode changes.
*/
module iq_input_stage
(
   input  logic                                  clk,
   input  logic                                  rst,
   input  hb_dec_pkg::dec_mode_e                 mode,
   input  logic                                  in_stb,
   input  hb_dec_pkg::iq_sample_t                in_sample,
   output logic                                  rail_stb,
   output logic signed [hb_dec_pkg::sample_w-1:0] rail_i,
   output logic signed [hb_dec_pkg::sample_w-1:0] rail_q,
   output logic                                  bypass,
   output logic                                  flush
);

   hb_dec_pkg::iq_sample_t sample_r;
   hb_dec_pkg::dec_mode_e  mode_r;

   always_ff @(posedge clk)
   begin
      sample_r <= in_sample;
      if (rst)
      begin
         rail_stb <= 1'b0;
         mode_r <= hb_dec_pkg::MODE_DECIMATE;
         flush <= 1'b0;
      end
      else
      begin
         rail_stb <= in_stb;
         mode_r <= mode;
         // flush lines up with the cycle in which bypass takes the new mode.
         flush <= (mode != mode_r);
      end
   end

   assign rail_i = sample_r.i;
   assign rail_q = sample_r.q;
   assign bypass = (mode_r == hb_dec_pkg::MODE_BYPASS);

endmodule

/* hw/iq_output_stage.sv */
`timescale 1ns/1ps
/*
   I/Q output stage.
   Joins the two filtered rails into one complex sample with a strobe and
   keeps a wrapping count of the samples delivered.
*/
module iq_output_stage
(
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  dec_stb_i,
   input  logic signed [hb_dec_pkg::sample_w-1:0] dec_data_i,
   input  logic signed [hb_dec_pkg::sample_w-1:0] dec_data_q,
   output logic                                  out_stb,
   output hb_dec_pkg::iq_sample_t                out_sample,
   output logic [hb_dec_pkg::count_w-1:0]        out_count
);

   // the Q rail runs in lockstep, so the I strobe qualifies both.
   always_ff @(posedge clk)
   begin
      if (dec_stb_i)
      begin
         out_sample.i <= dec_data_i;
         out_sample.q <= dec_data_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_stb <= 1'b0;
         out_count <= '0;
      end
      else
      begin
         out_stb <= dec_stb_i;
         if (dec_stb_i)
            out_count <= out_count + 1'b1;
      end
   end

endmodule

/* hw/hb_dec_top.sv */
`timescale 1ns/1ps
/*
   Complex receive half-band decimator.
   Input stage, one decimate-by-two filter per rail and an output stage
   that rejoins the pair and counts the delivered samples.
*/
module hb_dec_top
(
   input  logic                           clk,
   input  logic                           rst,
   input  hb_dec_pkg::dec_mode_e          mode,
   input  logic                           in_stb,
   input  hb_dec_pkg::iq_sample_t         in_sample,
   output logic                           out_stb,
   output hb_dec_pkg::iq_sample_t         out_sample,
   output logic [hb_dec_pkg::count_w-1:0] out_count
);

   logic                                  rail_stb;
   logic signed [hb_dec_pkg::sample_w-1:0] rail_i;
   logic signed [hb_dec_pkg::sample_w-1:0] rail_q;
   logic                                  bypass;
   logic                                  flush;
   logic                                  dec_stb_i;
   logic                                  dec_stb_q;
   logic signed [hb_dec_pkg::sample_w-1:0] dec_data_i;
   logic signed [hb_dec_pkg::sample_w-1:0] dec_data_q;

   iq_input_stage input_stage
   (
      .clk       (clk),
      .rst       (rst),
      .mode      (mode),
      .in_stb    (in_stb),
      .in_sample (in_sample),
      .rail_stb  (rail_stb),
      .rail_i    (rail_i),
      .rail_q    (rail_q),
      .bypass    (bypass),
      .flush     (flush)
   );

   // both rails share strobe, bypass and flush, so their phases match.
   small_hb_dec dec_i
   (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .bypass   (bypass),
      .stb_in   (rail_stb),
      .data_in  (rail_i),
      .stb_out  (dec_stb_i),
      .data_out (dec_data_i)
   );

   small_hb_dec dec_q
   (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .bypass   (bypass),
      .stb_in   (rail_stb),
      .data_in  (rail_q),
      .stb_out  (dec_stb_q),
      .data_out (dec_data_q)
   );

   iq_output_stage output_stage
   (
      .clk        (clk),
      .rst        (rst),
      .dec_stb_i  (dec_stb_i),
      .dec_data_i (dec_data_i),
      .dec_data_q (dec_data_q),
      .out_stb    (out_stb),
      .out_sample (out_sample),
      .out_count  (out_count)
   );

endmodule

/* tb/hb_dec_chk.sv */
`timescale 1ns/1ps
/*
   Protocol checks for the I/Q half-band decimator, bound to the top.
   Input strobe spacing, lockstep of the two rails and output reset.
*/
module hb_dec_chk
(
   input logic clk,
   input logic rst,
   input logic in_stb,
   input logic dec_stb_i,
   input logic dec_stb_q,
   input logic out_stb
);

   int unsigned fails = 0;

   // the source leaves at least one idle cycle between samples.
   assert property (@(posedge clk) disable iff (rst) in_stb |=> !in_stb)
   else
   begin
      $error("input strobe high on two consecutive cycles");
      fails++;
   end

   // both rails share strobe, bypass and flush, so they never drift apart.
   assert property (@(posedge clk) disable iff (rst) dec_stb_i == dec_stb_q)
   else
   begin
      $error("I and Q decimator strobes differ");
      fails++;
   end

   assert property (@(posedge clk) rst |=> !out_stb)
   else
   begin
      $error("output strobe high in the cycle after reset");
      fails++;
   end

endmodule

bind hb_dec_top hb_dec_chk chk_inst
(
   .clk       (clk),
   .rst       (rst),
   .in_stb    (in_stb),
   .dec_stb_i (dec_stb_i),
   .dec_stb_q (dec_stb_q),
   .out_stb   (out_stb)
);

/* tb/hb_dec_tb.sv */
`timescale 1ns/1ps
/*
   Testbench for the complex half-band decimator.
   LCG driven I/Q streams in both modes, a bit-exact model of the filter,
   and a scoreboard on value, output cycle and sample count.
*/
module hb_dec_tb;

   localparam int n_impulse = 20;
   localparam int n_random = 200;
   // an odd count leaves the filter phase set when the mode flush arrives.
   localparam int n_bypass = 41;
   localparam int n_switch = 41;
   localparam int n_after = 40;
   // each sample spans at most four cycles, then mode switches, resets and the drain.
   localparam int stim_cycles = (n_impulse + n_random + n_bypass + n_switch + n_after) * 4
                                + 2 * 15 + 2 * 8 + 12;
   localparam int max_cycles = stim_cycles * 4 + 100;

   typedef struct packed
   {
      hb_dec_pkg::iq_sample_t         smp;
      logic [31:0]                    due;
      logic [hb_dec_pkg::count_w-1:0] cnt;
   } expect_t;

   logic                                 clk;
   logic                                 rst;
   hb_dec_pkg::dec_mode_e                mode;
   logic                                 in_stb;
   hb_dec_pkg::iq_sample_t               in_sample;
   logic                                 out_stb;
   hb_dec_pkg::iq_sample_t               out_sample;
   logic [hb_dec_pkg::count_w-1:0]       out_count;

   logic [31:0]                          lcg_state = 32'hb8a0;
   int                                   cycle = 0;
   int                                   checks = 0;
   int                                   errors = 0;
   expect_t                              exp_q[$];
   expect_t                              head;
   logic [hb_dec_pkg::count_w-1:0]       exp_count;
   logic [5:0][hb_dec_pkg::sample_w-1:0] hist_i;
   logic [5:0][hb_dec_pkg::sample_w-1:0] hist_q;
   logic                                 phase;

   hb_dec_top hb_dec_top_inst
   (
      .clk        (clk),
      .rst        (rst),
      .mode       (mode),
      .in_stb     (in_stb),
      .in_sample  (in_sample),
      .out_stb    (out_stb),
      .out_sample (out_sample),
      .out_count  (out_count)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (cycle > max_cycles)
      begin
         $display("timeout: no end of test after %0d cycles", max_cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic hb_dec_pkg::iq_sample_t random_sample();
      hb_dec_pkg::iq_sample_t s;
      logic [31:0] r;
      r = lcg_next();
      s.i = r[31:14];
      r = lcg_next();
      s.q = r[31:14];
      return s;
   endfunction

   // x0 is the newest sample, h[k] is the sample k+1 back.
   function automatic logic signed [hb_dec_pkg::sample_w-1:0] filter_out
   (
      input logic signed [hb_dec_pkg::sample_w-1:0] x0,
      input logic [5:0][hb_dec_pkg::sample_w-1:0]   h
   );
      longint outer;
      longint inner;
      longint acc;
      outer = (longint'(x0) + longint'($signed(h[5]))) >>> 1;
      inner = (longint'($signed(h[1])) + longint'($signed(h[3]))) >>> 1;
      acc = longint'($signed(h[2])) * 65536;
      acc = acc + longint'(hb_dec_pkg::coeff_a) * outer;
      acc = acc + longint'(hb_dec_pkg::coeff_b) * inner;
      // round to nearest, halves upward.
      acc = (acc + 131072) >>> 18;
      return acc[hb_dec_pkg::sample_w-1:0];
   endfunction

   task automatic check_value(input string what, input logic signed [63:0] got,
                              input logic signed [63:0] want);
      checks++;
      if (got !== want)
      begin
         $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
         errors++;
      end
   endtask

   task automatic clear_model();
      hist_i = '0;
      hist_q = '0;
      phase = 1'b0;
   endtask

   // predicts the output of one input sample, if it produces one.
   task automatic model_step(input hb_dec_pkg::iq_sample_t s);
      expect_t e;
      logic    emit;
      emit = 1'b0;
      if (mode == hb_dec_pkg::MODE_BYPASS)
      begin
         e.smp = s;
         e.due = cycle + 4;
         emit = 1'b1;
      end
      else
      begin
         if (phase)
         begin
            e.smp.i = filter_out(s.i, hist_i);
            e.smp.q = filter_out(s.q, hist_q);
            e.due = cycle + 8;
            emit = 1'b1;
         end
         hist_i = {hist_i[4:0], s.i};
         hist_q = {hist_q[4:0], s.q};
         phase = ~phase;
      end
      if (emit)
      begin
         exp_count = exp_count + 1'b1;
         e.cnt = exp_count;
         exp_q.push_back(e);
      end
   endtask

   // called on a falling edge, returns on a falling edge after 1 to 3 idle cycles.
   task automatic send_sample(input hb_dec_pkg::iq_sample_t s);
      logic [31:0] r;
      r = lcg_next();
      in_stb = 1'b1;
      in_sample = s;
      model_step(s);
      @(negedge clk);
      in_stb = 1'b0;
      repeat ((r[31:16] % 3) + 1) @(negedge clk);
   endtask

   task automatic send_random(input int n);
      for (int k = 0; k < n; k++)
         send_sample(random_sample());
   endtask

   task automatic send_impulse(input int lead);
      hb_dec_pkg::iq_sample_t zero;
      hb_dec_pkg::iq_sample_t peak;
      zero = '0;
      peak.i = 18'sd131071;
      peak.q = 18'sd131071;
      for (int k = 0; k < 10; k++)
         send_sample((k == lead) ? peak : zero);
   endtask

   task automatic reset_dut();
      rst = 1'b1;
      in_stb = 1'b0;
      @(negedge clk);
      exp_q.delete();
      exp_count = '0;
      clear_model();
      check_value("out_count after reset", out_count, 0);
      repeat (7) @(negedge clk);
      rst = 1'b0;
   endtask

   // lets the pipeline drain before the mode flush restarts the filters.
   task automatic switch_mode(input hb_dec_pkg::dec_mode_e m);
      repeat (12) @(negedge clk);
      mode = m;
      clear_model();
      repeat (3) @(negedge clk);
   endtask

   always @(negedge clk)
   begin
      if (out_stb)
      begin
         if (exp_q.size() == 0)
         begin
            $display("error at %0t ns: output sample delivered while none was expected",
                     $time);
            errors++;
         end
         else
         begin
            head = exp_q.pop_front();
            check_value("out_sample.i", out_sample.i, head.smp.i);
            check_value("out_sample.q", out_sample.q, head.smp.q);
            check_value("out_count", out_count, head.cnt);
            check_value("out_stb cycle", cycle, head.due);
         end
      end
   end

   initial
   begin
      rst = 1'b1;
      mode = hb_dec_pkg::MODE_DECIMATE;
      in_stb = 1'b0;
      in_sample = '0;
      reset_dut();
      // the impulse lands on the centre tap first, then on the A and B taps.
      send_impulse(0);
      send_impulse(1);
      send_random(n_random);
      switch_mode(hb_dec_pkg::MODE_BYPASS);
      send_random(n_bypass);
      switch_mode(hb_dec_pkg::MODE_DECIMATE);
      send_random(n_switch);
      reset_dut();
      send_random(n_after);
      repeat (12) @(negedge clk);
      if (exp_q.size() != 0)
      begin
         $display("error: %0d expected output samples never appeared", exp_q.size());
         errors++;
      end
      errors = errors + hb_dec_top_inst.chk_inst.fails;
      $display("checks: %0d, errors: %0d (assertion failures: %0d)",
               checks, errors, hb_dec_top_inst.chk_inst.fails);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* flist.f */
hw/hb_dec_pkg.sv
hw/hb_round.sv
hw/hb_mult18.sv
hw/small_hb_dec.sv
hw/iq_input_stage.sv
hw/iq_output_stage.sv
hw/hb_dec_top.sv
tb/hb_dec_chk.sv
tb/hb_dec_tb.sv

/* run.sh */
#!/bin/sh
# Builds the half-band decimator testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module hb_dec_tb \
   -f flist.f -Mdir obj_dir -o hb_dec_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/hb_dec_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
